//--- design/video_macros.svh
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// Horizontal geometry in pixels
`define H_ACTIVE      (64)
`define H_TOTAL       (80)
`define H_SYNC_START  (68)
`define H_SYNC_LEN    (6)

// Vertical geometry in lines
`define V_ACTIVE      (48)
`define V_TOTAL       (52)
`define V_SYNC_START  (49)
`define V_SYNC_LEN    (2)

// Clocks per pixel
`define PIX_DIV       (4)

// Frame memory word address
`define FB_ADDR_W     (12)
`define FB_WORDS      (`H_ACTIVE * `V_ACTIVE)

// Luma weights, sum is 256
`define LUMA_R        (77)
`define LUMA_G        (150)
`define LUMA_B        (29)

`endif

//--- design/video_pkg.sv
package video_pkg;

  // Video side view of a frame word
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } pixel_rgb_t;

  // Same word, raw on the host side
  typedef union packed {
    logic [23:0] raw;
    pixel_rgb_t  rgb;
  } pixel_word_t;

endpackage

//--- design/frame_bus_if.sv
`timescale 1ns/100ps
`include "video_macros.svh"

interface frame_bus_if;

  logic                  cyc;
  logic                  stb;
  logic                  we;
  logic [`FB_ADDR_W-1:0] adr;
  logic [23:0]           dat_w;
  logic [23:0]           dat_r;
  logic                  ack;

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

//--- design/video_timing.sv
`timescale 1ns/100ps
`include "video_macros.svh"

module video_timing (
  input  logic clk,
  input  logic arst_n,
  output logic pix_tick,
  output logic hsync,
  output logic vsync,
  output logic de,
  output logic frame_start
);

  localparam int DIV_W = $clog2(`PIX_DIV);
  localparam int H_W   = $clog2(`H_TOTAL);
  localparam int V_W   = $clog2(`V_TOTAL);

  logic [DIV_W-1:0] div_cnt;
  logic [H_W-1:0]   h_cnt;
  logic [V_W-1:0]   v_cnt;

  // Pixel divider, then pixel and line counters
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= '0;
      h_cnt   <= '0;
      v_cnt   <= '0;
    end else if (div_cnt == `PIX_DIV - 1) begin
      div_cnt <= '0;
      if (h_cnt == `H_TOTAL - 1) begin
        h_cnt <= '0;
        v_cnt <= (v_cnt == `V_TOTAL - 1) ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Decoded outputs, all change on the tick clock of a pixel
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pix_tick    <= 1'b0;
      hsync       <= 1'b0;
      vsync       <= 1'b0;
      de          <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      pix_tick    <= (div_cnt == 0);
      hsync       <= (h_cnt >= `H_SYNC_START) && (h_cnt < `H_SYNC_START + `H_SYNC_LEN);
      vsync       <= (v_cnt >= `V_SYNC_START) && (v_cnt < `V_SYNC_START + `V_SYNC_LEN);
      de          <= (h_cnt < `H_ACTIVE) && (v_cnt < `V_ACTIVE);
      frame_start <= (div_cnt == 0) && (h_cnt == 0) && (v_cnt == `V_SYNC_START);
    end
  end

  // Active area clear of both syncs, and de edges only on a pixel tick
  a_de_in_active: assert property (@(posedge clk) disable iff (!arst_n)
    (de |-> !hsync && !vsync) and ($changed(de) |-> pix_tick));

endmodule

//--- design/frame_reader.sv
`timescale 1ns/100ps
`include "video_macros.svh"

module frame_reader (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     pix_tick,
  input  logic                     de,
  input  logic                     frame_start,
  frame_bus_if.master              bus,
  output video_pkg::pixel_word_t   pixel
);

  video_pkg::pixel_word_t fifo_mem [4];

  logic [1:0]            wr_ptr;
  logic [1:0]            rd_ptr;
  logic [2:0]            count;
  logic [2:0]            count_next;
  logic [`FB_ADDR_W-1:0] rd_addr;
  logic [`FB_ADDR_W-1:0] rd_addr_next;
  logic                  req;
  logic                  armed;
  logic                  push;
  logic                  pop;

  // Ack reaches this port only for its own read
  assign push = req && bus.ack;
  assign pop  = armed && pix_tick && de && (count != 0);

  always_comb begin
    count_next   = count + {2'b00, push} - {2'b00, pop};
    rd_addr_next = push ? rd_addr + 1'b1 : rd_addr;
  end

  // Scan-out idles until the first frame start after reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      armed   <= 1'b0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      rd_addr <= '0;
      req     <= 1'b0;
    end else if (frame_start) begin
      armed   <= 1'b1;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      rd_addr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count   <= count_next;
      rd_addr <= rd_addr_next;
      // Keep one read in flight while the FIFO has a free slot
      if (push || !req) begin
        req <= armed && (count_next < 3'd4) && (rd_addr_next != `FB_WORDS);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr].raw <= bus.dat_r;
    end
  end

  assign bus.cyc   = req;
  assign bus.stb   = req;
  assign bus.we    = 1'b0;
  assign bus.adr   = rd_addr;
  assign bus.dat_w = '0;

  assign pixel = armed ? fifo_mem[rd_ptr] : '0;

  a_no_underrun: assert property (@(posedge clk) disable iff (!arst_n)
    (armed && pix_tick && de) |-> (count != 0));

  // Flush would lose a read still in flight
  a_idle_at_frame_start: assert property (@(posedge clk) disable iff (!arst_n)
    frame_start |-> !req);

endmodule

//--- design/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter (
  input  logic        clk,
  input  logic        arst_n,
  frame_bus_if.slave  reader,
  frame_bus_if.slave  host,
  frame_bus_if.master mem
);

  logic reader_req;
  logic host_req;
  logic locked;
  logic owner_host;
  logic sel_host;

  assign reader_req = reader.cyc && reader.stb;
  assign host_req   = host.cyc && host.stb;

  // Reader wins at idle, otherwise the locked owner keeps the bus
  assign sel_host = locked ? owner_host : (host_req && !reader_req);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      locked     <= 1'b0;
      owner_host <= 1'b0;
    end else if (mem.ack) begin
      locked <= 1'b0;
    end else if (!locked && mem.cyc && mem.stb) begin
      locked     <= 1'b1;
      owner_host <= sel_host;
    end
  end

  // Request path
  assign mem.cyc   = sel_host ? host.cyc   : reader.cyc;
  assign mem.stb   = sel_host ? host.stb   : reader.stb;
  assign mem.we    = sel_host ? host.we    : reader.we;
  assign mem.adr   = sel_host ? host.adr   : reader.adr;
  assign mem.dat_w = sel_host ? host.dat_w : reader.dat_w;

  // Response path, granted master only
  assign reader.ack   = mem.ack && !sel_host;
  assign host.ack     = mem.ack && sel_host;
  assign reader.dat_r = sel_host ? '0 : mem.dat_r;
  assign host.dat_r   = sel_host ? mem.dat_r : '0;

  // Memory ack reaches exactly one master, and only one that is requesting
  a_one_ack: assert property (@(posedge clk) disable iff (!arst_n)
    mem.ack |-> $onehot({reader.ack && reader_req, host.ack && host_req}));

  // Grant must not switch under a pending request
  a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (mem.cyc && mem.stb && !mem.ack) |=>
      (mem.stb && $stable(mem.adr) && $stable(mem.we)));

endmodule

//--- design/frame_mem.sv
`timescale 1ns/100ps
`include "video_macros.svh"

module frame_mem (
  input  logic       clk,
  input  logic       arst_n,
  frame_bus_if.slave bus
);

  logic [23:0] mem_array [`FB_WORDS];
  logic [23:0] rd_data;
  logic        ack_q;
  logic        access;

  // New access only when the last ack has gone
  assign access = bus.cyc && bus.stb && !ack_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (bus.we) begin
        mem_array[bus.adr] <= bus.dat_w;
      end
      rd_data <= mem_array[bus.adr];
    end
  end

  assign bus.ack   = ack_q;
  assign bus.dat_r = rd_data;

endmodule

//--- design/pixel_shader.sv
`timescale 1ns/100ps
`include "video_macros.svh"

module pixel_shader (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   gray_mode,
  input  logic                   pix_tick,
  input  logic                   hsync_in,
  input  logic                   vsync_in,
  input  logic                   de_in,
  input  video_pkg::pixel_word_t pixel,
  output logic                   hsync,
  output logic                   vsync,
  output logic                   de,
  output logic                   pixel_valid,
  output logic [7:0]             red,
  output logic [7:0]             green,
  output logic [7:0]             blue
);

  logic [15:0] luma_sum;
  logic [7:0]  luma;
  logic [7:0]  out_r;
  logic [7:0]  out_g;
  logic [7:0]  out_b;

  // Weighted luma, weights sum to 256
  always_comb begin
    luma_sum = 16'(`LUMA_R) * {8'd0, pixel.rgb.red}
             + 16'(`LUMA_G) * {8'd0, pixel.rgb.green}
             + 16'(`LUMA_B) * {8'd0, pixel.rgb.blue};
    luma = luma_sum[15:8];
    if (gray_mode) begin
      out_r = luma;
      out_g = luma;
      out_b = luma;
    end else begin
      out_r = pixel.rgb.red;
      out_g = pixel.rgb.green;
      out_b = pixel.rgb.blue;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hsync       <= 1'b0;
      vsync       <= 1'b0;
      de          <= 1'b0;
      pixel_valid <= 1'b0;
      red         <= '0;
      green       <= '0;
      blue        <= '0;
    end else begin
      hsync       <= hsync_in;
      vsync       <= vsync_in;
      de          <= de_in;
      pixel_valid <= pix_tick && de_in;
      // Color held for the whole pixel, black in blanking
      if (pix_tick) begin
        red   <= de_in ? out_r : '0;
        green <= de_in ? out_g : '0;
        blue  <= de_in ? out_b : '0;
      end
    end
  end

endmodule

//--- design/video_pipeline_top.sv
`timescale 1ns/100ps
`include "video_macros.svh"

module video_pipeline_top (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  gray_mode,
  input  logic                  host_cyc,
  input  logic                  host_stb,
  input  logic                  host_we,
  input  logic [`FB_ADDR_W-1:0] host_adr,
  input  logic [23:0]           host_dat_w,
  output logic [23:0]           host_dat_r,
  output logic                  host_ack,
  output logic                  hsync,
  output logic                  vsync,
  output logic                  de,
  output logic                  pixel_valid,
  output logic [7:0]            red,
  output logic [7:0]            green,
  output logic [7:0]            blue
);

  frame_bus_if reader_bus ();
  frame_bus_if host_bus ();
  frame_bus_if mem_bus ();

  logic                   pix_tick;
  logic                   tm_hsync;
  logic                   tm_vsync;
  logic                   tm_de;
  logic                   frame_start;
  video_pkg::pixel_word_t fifo_pixel;

  // Host port onto its bus
  assign host_bus.cyc   = host_cyc;
  assign host_bus.stb   = host_stb;
  assign host_bus.we    = host_we;
  assign host_bus.adr   = host_adr;
  assign host_bus.dat_w = host_dat_w;
  assign host_dat_r     = host_bus.dat_r;
  assign host_ack       = host_bus.ack;

  video_timing u_video_timing (
    .clk         (clk),
    .arst_n      (arst_n),
    .pix_tick    (pix_tick),
    .hsync       (tm_hsync),
    .vsync       (tm_vsync),
    .de          (tm_de),
    .frame_start (frame_start)
  );

  frame_reader u_frame_reader (
    .clk         (clk),
    .arst_n      (arst_n),
    .pix_tick    (pix_tick),
    .de          (tm_de),
    .frame_start (frame_start),
    .bus         (reader_bus.master),
    .pixel       (fifo_pixel)
  );

  bus_arbiter u_bus_arbiter (
    .clk    (clk),
    .arst_n (arst_n),
    .reader (reader_bus.slave),
    .host   (host_bus.slave),
    .mem    (mem_bus.master)
  );

  frame_mem u_frame_mem (
    .clk    (clk),
    .arst_n (arst_n),
    .bus    (mem_bus.slave)
  );

  pixel_shader u_pixel_shader (
    .clk         (clk),
    .arst_n      (arst_n),
    .gray_mode   (gray_mode),
    .pix_tick    (pix_tick),
    .hsync_in    (tm_hsync),
    .vsync_in    (tm_vsync),
    .de_in       (tm_de),
    .pixel       (fifo_pixel),
    .hsync       (hsync),
    .vsync       (vsync),
    .de          (de),
    .pixel_valid (pixel_valid),
    .red         (red),
    .green       (green),
    .blue        (blue)
  );

endmodule

//--- test/video_checker.sv
`timescale 1ns/100ps
`include "video_macros.svh"

module video_checker (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  gray_mode,
  input  logic                  check_en,
  input  logic                  host_cyc,
  input  logic                  host_stb,
  input  logic                  host_we,
  input  logic [`FB_ADDR_W-1:0] host_adr,
  input  logic [23:0]           host_dat_w,
  input  logic [23:0]           host_dat_r,
  input  logic                  host_ack,
  input  logic                  hsync,
  input  logic                  vsync,
  input  logic                  de,
  input  logic                  pixel_valid,
  input  logic [7:0]            red,
  input  logic [7:0]            green,
  input  logic [7:0]            blue,
  output int                    error_count,
  output int                    pixel_count,
  output int                    read_count,
  output int                    frames_checked
);

  localparam int VSYNC_CLOCKS = `V_SYNC_LEN * `H_TOTAL * `PIX_DIV;

  // Latest host view, and the copy taken at frame start for scan-out
  logic [23:0] pending_frame [`FB_WORDS];
  logic [23:0] shown_frame   [`FB_WORDS];
  logic [23:0] expected;
  logic        frame_seen;
  logic        frame_check;
  logic        last_vsync;
  logic        last_hsync;
  logic        last_valid;
  int          pix_idx;
  int          line_pix;
  int          active_lines;
  int          hsync_pulses;
  int          vsync_clocks;
  int          de_clocks;
  int          i;

  // 8 bit fraction weights, result is the top byte
  function automatic logic [7:0] luma_of(input logic [23:0] word);
    int sum;
    begin
      sum = `LUMA_R * word[23:16] + `LUMA_G * word[15:8] + `LUMA_B * word[7:0];
      luma_of = 8'(sum >> 8);
    end
  endfunction

  task automatic check_value(input string what, input logic [23:0] got,
                             input logic [23:0] exp);
    begin
      if (got !== exp) begin
        $display("Error: %s expected %h got %h", what, exp, got);
        error_count++;
      end
    end
  endtask

  initial begin
    error_count    = 0;
    pixel_count    = 0;
    read_count     = 0;
    frames_checked = 0;
    frame_seen     = 1'b0;
    frame_check    = 1'b0;
    last_vsync     = 1'b0;
    last_hsync     = 1'b0;
    last_valid     = 1'b0;
  end

  // Everything sampled on the falling edge, away from register updates
  always @(negedge clk) begin
    if (!arst_n) begin
      check_value("hsync in reset", 24'(hsync), 24'h0);
      check_value("vsync in reset", 24'(vsync), 24'h0);
      check_value("de in reset", 24'(de), 24'h0);
      check_value("pixel_valid in reset", 24'(pixel_valid), 24'h0);
      check_value("rgb in reset", {red, green, blue}, 24'h0);
      check_value("host_ack in reset", 24'(host_ack), 24'h0);
    end else begin
      if (host_ack && host_cyc && host_stb) begin
        if (host_we) begin
          pending_frame[host_adr] = host_dat_w;
        end else begin
          check_value($sformatf("host_dat_r at address %h", host_adr), host_dat_r,
                      pending_frame[host_adr]);
          read_count++;
        end
      end

      // New frame begins at the vsync rise
      if (vsync && !last_vsync) begin
        if (frame_seen) begin
          check_value("active line count", 24'(active_lines), 24'(`V_ACTIVE));
          check_value("hsync pulse count", 24'(hsync_pulses), 24'(`V_TOTAL));
          if (frame_check) begin
            frames_checked++;
          end
        end
        frame_seen   = 1'b1;
        frame_check  = check_en;
        pix_idx      = 0;
        line_pix     = 0;
        active_lines = 0;
        hsync_pulses = 0;
        vsync_clocks = 0;
        de_clocks    = 0;
        for (i = 0; i < `FB_WORDS; i++) begin
          shown_frame[i] = pending_frame[i];
        end
      end
      if (vsync) begin
        vsync_clocks++;
      end
      if (!vsync && last_vsync && frame_seen) begin
        check_value("vsync width in clocks", 24'(vsync_clocks), 24'(VSYNC_CLOCKS));
      end

      // Each pixel holds de for one pixel period
      if (de && frame_seen) begin
        de_clocks++;
      end

      if (hsync && !last_hsync && frame_seen) begin
        hsync_pulses++;
        check_value("de clocks in line", 24'(de_clocks), 24'(line_pix * `PIX_DIV));
        if (line_pix == `H_ACTIVE) begin
          active_lines++;
        end else if (line_pix != 0) begin
          check_value("pixels in line", 24'(line_pix), 24'(`H_ACTIVE));
        end
        line_pix  = 0;
        de_clocks = 0;
      end

      if (pixel_valid && frame_seen) begin
        if (last_valid) begin
          $display("pixel_valid stayed high for more than one clock at pixel %0d", pix_idx);
          error_count++;
        end
        check_value($sformatf("de at pixel %0d", pix_idx), 24'(de), 24'h1);
        if (frame_check && pix_idx < `FB_WORDS) begin
          expected = shown_frame[pix_idx];
          if (gray_mode) begin
            expected = {3{luma_of(expected)}};
          end
          check_value($sformatf("red at pixel %0d", pix_idx), 24'(red), 24'(expected[23:16]));
          check_value($sformatf("green at pixel %0d", pix_idx), 24'(green),
                      24'(expected[15:8]));
          check_value($sformatf("blue at pixel %0d", pix_idx), 24'(blue), 24'(expected[7:0]));
          pixel_count++;
        end
        pix_idx++;
        line_pix++;
      end

      last_vsync = vsync;
      last_hsync = hsync;
      last_valid = pixel_valid;
    end
  end

endmodule

//--- test/tb_video_pipeline.sv
`timescale 1ns/100ps
`include "video_macros.svh"

module tb_video_pipeline;

  localparam int ACK_TIMEOUT   = 64;
  localparam int FRAME_TIMEOUT = 2 * `V_TOTAL * `H_TOTAL * `PIX_DIV;
  localparam int HOST_READS    = 32;
  localparam int HOST_EDITS    = 16;

  logic                  clk;
  logic                  arst_n;
  logic                  gray_mode;
  logic                  check_en;
  logic                  host_cyc;
  logic                  host_stb;
  logic                  host_we;
  logic [`FB_ADDR_W-1:0] host_adr;
  logic [23:0]           host_dat_w;
  logic [23:0]           host_dat_r;
  logic                  host_ack;
  logic                  hsync;
  logic                  vsync;
  logic                  de;
  logic                  pixel_valid;
  logic [7:0]            red;
  logic [7:0]            green;
  logic [7:0]            blue;

  integer                seed;
  logic [31:0]           rnd;
  int                    idx;
  int                    timeout_count;
  int                    error_count;
  int                    pixel_count;
  int                    read_count;
  int                    frames_checked;

  always #10 clk = ~clk;

  video_pipeline_top u_video_pipeline_top (
    .clk         (clk),
    .arst_n      (arst_n),
    .gray_mode   (gray_mode),
    .host_cyc    (host_cyc),
    .host_stb    (host_stb),
    .host_we     (host_we),
    .host_adr    (host_adr),
    .host_dat_w  (host_dat_w),
    .host_dat_r  (host_dat_r),
    .host_ack    (host_ack),
    .hsync       (hsync),
    .vsync       (vsync),
    .de          (de),
    .pixel_valid (pixel_valid),
    .red         (red),
    .green       (green),
    .blue        (blue)
  );

  video_checker u_video_checker (
    .clk            (clk),
    .arst_n         (arst_n),
    .gray_mode      (gray_mode),
    .check_en       (check_en),
    .host_cyc       (host_cyc),
    .host_stb       (host_stb),
    .host_we        (host_we),
    .host_adr       (host_adr),
    .host_dat_w     (host_dat_w),
    .host_dat_r     (host_dat_r),
    .host_ack       (host_ack),
    .hsync          (hsync),
    .vsync          (vsync),
    .de             (de),
    .pixel_valid    (pixel_valid),
    .red            (red),
    .green          (green),
    .blue           (blue),
    .error_count    (error_count),
    .pixel_count    (pixel_count),
    .read_count     (read_count),
    .frames_checked (frames_checked)
  );

  task automatic end_of_run;
    begin
      $display("Summary: %0d pixels and %0d host reads compared, %0d errors, %0d timeouts",
               pixel_count, read_count, error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  endtask

  // One classic cycle, released in the clock after ack
  task automatic host_access(input logic write, input logic [`FB_ADDR_W-1:0] adr,
                             input logic [23:0] data);
    int cycles;
    begin
      if (timeout_count == 0) begin
        host_cyc   = 1'b1;
        host_stb   = 1'b1;
        host_we    = write;
        host_adr   = adr;
        host_dat_w = data;
        cycles     = 0;
        while (!host_ack && cycles < ACK_TIMEOUT) begin
          @(posedge clk);
          #2;
          cycles++;
        end
        if (!host_ack) begin
          $display("Timeout: host access to address %h got no ack", adr);
          timeout_count++;
        end
        @(posedge clk);
        #2;
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_we  = 1'b0;
      end
    end
  endtask

  // Returns just after the output vsync rises
  task automatic wait_frame_start;
    int   cycles;
    logic seen;
    logic last;
    begin
      if (timeout_count == 0) begin
        cycles = 0;
        seen   = 1'b0;
        last   = vsync;
        while (!seen && cycles < FRAME_TIMEOUT) begin
          @(posedge clk);
          #2;
          seen = vsync && !last;
          last = vsync;
          cycles++;
        end
        if (!seen) begin
          $display("Timeout: no frame start seen");
          timeout_count++;
        end
      end
    end
  endtask

  task automatic skip_lines(input int count);
    int   cycles;
    int   seen;
    logic last;
    begin
      if (timeout_count == 0) begin
        cycles = 0;
        seen   = 0;
        last   = hsync;
        while (seen < count && cycles < FRAME_TIMEOUT) begin
          @(posedge clk);
          #2;
          if (hsync && !last) begin
            seen++;
          end
          last = hsync;
          cycles++;
        end
        if (seen < count) begin
          $display("Timeout: only %0d of %0d hsync pulses seen", seen, count);
          timeout_count++;
        end
      end
    end
  endtask

  task automatic wait_checked_frames(input int count);
    int cycles;
    begin
      if (timeout_count == 0) begin
        cycles = 0;
        while (frames_checked < count && cycles < FRAME_TIMEOUT) begin
          @(posedge clk);
          #2;
          cycles++;
        end
        if (frames_checked < count) begin
          $display("Timeout: only %0d of %0d frames were compared", frames_checked, count);
          timeout_count++;
        end
      end
    end
  endtask

  initial begin
    clk           = 1'b0;
    arst_n        = 1'b1;
    gray_mode     = 1'b0;
    check_en      = 1'b0;
    host_cyc      = 1'b0;
    host_stb      = 1'b0;
    host_we       = 1'b0;
    host_adr      = '0;
    host_dat_w    = '0;
    seed          = 32'h363d9836;
    timeout_count = 0;
    #1 arst_n = 1'b0;
    repeat (2) @(posedge clk);
    #2 arst_n = 1'b1;

    // Load a random frame while the first armed frame is unchecked
    wait_frame_start();
    for (idx = 0; idx < `FB_WORDS; idx++) begin
      rnd = $random(seed);
      host_access(1'b1, `FB_ADDR_W'(idx), rnd[23:0]);
    end
    check_en = 1'b1;

    // Color frame, host reads mixed into active video
    wait_frame_start();
    skip_lines(10);
    for (idx = 0; idx < HOST_READS; idx++) begin
      rnd = $random(seed);
      host_access(1'b0, `FB_ADDR_W'(rnd % `FB_WORDS), 24'h0);
    end

    // Gray frame, edits go to lines 0 to 15 once they are shown
    wait_frame_start();
    gray_mode = 1'b1;
    skip_lines(23);
    for (idx = 0; idx < HOST_EDITS; idx++) begin
      rnd = $random(seed);
      host_adr = `FB_ADDR_W'(rnd % (16 * `H_ACTIVE));
      rnd = $random(seed);
      host_access(1'b1, host_adr, rnd[23:0]);
    end

    // Color frame that shows the edits
    wait_frame_start();
    gray_mode = 1'b0;
    wait_checked_frames(3);
    end_of_run();
  end

endmodule

//--- video_pipeline_top.f
+incdir+design
design/video_pkg.sv
design/frame_bus_if.sv
design/video_timing.sv
design/frame_reader.sv
design/bus_arbiter.sv
design/frame_mem.sv
design/pixel_shader.sv
design/video_pipeline_top.sv
test/video_checker.sv
test/tb_video_pipeline.sv
